// File: common/rv_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I instruction set definitions
// major opcodes, branch funct3 codes, ALU operations and the
// immediate decoders for the I, S, B, U and J formats
//////////////////////////////////////////////////////////////////////

package rv_isa_pkg;

  // data path width, RV32 only
  localparam int unsigned XLEN = 32;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opc_t;

  // branch conditions, unsigned variants not supported
  typedef enum logic [2:0] {
    BEQ = 3'b000,
    BNE = 3'b001,
    BLT = 3'b100,
    BGE = 3'b101
  } fn3_br_t;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    PASS_B
  } alu_op_t;

  // sign extended immediates
  function automatic logic [XLEN-1:0] imm_i(input logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic logic [XLEN-1:0] imm_s(input logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic logic [XLEN-1:0] imm_b(input logic [31:0] ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] imm_u(input logic [31:0] ins);
    return {ins[31:12], 12'h000};
  endfunction

  function automatic logic [XLEN-1:0] imm_j(input logic [31:0] ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

endpackage

// File: common/core_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// core bus and control types
// request and response payloads of the valid/ready buses,
// write-back source select and the decoded instruction control
//////////////////////////////////////////////////////////////////////

package core_bus_pkg;

  import rv_isa_pkg::*;

  // write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LSU,
    WB_PC4,
    WB_NONE
  } wb_sel_t;

  // decoded instruction control
  typedef struct packed {
    opc_t            opc;
    alu_op_t         alu_op;
    // operand A from pc instead of rs1
    logic            a_pc;
    // operand B from immediate instead of rs2
    logic            b_imm;
    fn3_br_t         br_fn3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    wb_sel_t         wb_sel;
  } dec_t;

  // bus request, byte enables kept for a full word
  typedef struct packed {
    logic            wen;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] wdt;
    logic [3:0]      ben;
  } bus_req_t;

  // bus response, valid the cycle after the transfer
  typedef struct packed {
    logic [XLEN-1:0] rdt;
    logic            err;
  } bus_rsp_t;

endpackage

// File: hdl/core_gpr.sv
//////////////////////////////////////////////////////////////////////
// general purpose register file
// 32 x XLEN, two asynchronous reads, one synchronous write,
// x0 reads as zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_gpr (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [4:0]                   rs1_adr,
  input  logic [4:0]                   rs2_adr,
  input  logic                         rd_en,
  input  logic [4:0]                   rd_adr,
  input  logic [rv_isa_pkg::XLEN-1:0]  rd_dat,
  output logic [rv_isa_pkg::XLEN-1:0]  rs1_dat,
  output logic [rv_isa_pkg::XLEN-1:0]  rs2_dat
);

  import rv_isa_pkg::*;

  logic [XLEN-1:0] gpr_q [0:31];

  // all entries cleared at reset
  // entry 0 is never written
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (rd_en && rd_adr != 5'd0) begin
      gpr_q[rd_adr] <= rd_dat;
    end
  end

  // x0 forced to zero on the read side
  assign rs1_dat = (rs1_adr == 5'd0) ? '0 : gpr_q[rs1_adr];
  assign rs2_dat = (rs2_adr == 5'd0) ? '0 : gpr_q[rs2_adr];

endmodule

// File: hdl/core_alu.sv
//////////////////////////////////////////////////////////////////////
// arithmetic logic unit
// operand select, integer ops, a 33 bit sum side output shared by
// address/target math, set-less-than and the branch comparator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_alu (
  input  core_bus_pkg::dec_t           ctl,
  input  logic [rv_isa_pkg::XLEN-1:0]  pc,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs1,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs2,
  output logic [rv_isa_pkg::XLEN-1:0]  rd,
  output logic [rv_isa_pkg::XLEN:0]    sum,
  output logic                         tkn
);

  import rv_isa_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN:0]   ext_a;
  logic [XLEN:0]   ext_b;
  logic            sgn;
  logic            sub;

  // operand muxes
  assign op_a = ctl.a_pc  ? pc      : rs1;
  assign op_b = ctl.b_imm ? ctl.imm : rs2;

  // signed compare extends by sign, otherwise by zero
  assign sgn = (ctl.alu_op == SLT);
  assign sub = ctl.alu_op inside {SUB, SLT, SLTU};

  assign ext_a = {sgn & op_a[XLEN-1], op_a};
  assign ext_b = {sgn & op_b[XLEN-1], op_b};

  // msb of a difference is the less-than flag
  assign sum = sub ? (ext_a - ext_b) : (ext_a + ext_b);

  always_comb begin
    case (ctl.alu_op)
      ADD, SUB : rd = sum[XLEN-1:0];
      AND      : rd = op_a & op_b;
      OR       : rd = op_a | op_b;
      XOR      : rd = op_a ^ op_b;
      SLT, SLTU: rd = {{(XLEN-1){1'b0}}, sum[XLEN]};
      PASS_B   : rd = op_b;
      default  : rd = sum[XLEN-1:0];
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // branch condition
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tkn = 1'b0;
    if (ctl.opc == BRANCH) begin
      case (ctl.br_fn3)
        BEQ    : tkn = ~(|sum[XLEN-1:0]);
        BNE    : tkn =   |sum[XLEN-1:0];
        BLT    : tkn =    sum[XLEN];
        BGE    : tkn =   ~sum[XLEN];
        default: tkn = 1'b0;
      endcase
    end
  end

endmodule

// File: hdl/core_idu.sv
//////////////////////////////////////////////////////////////////////
// instruction decoder
// 32 bit RV32I subset into the control struct, anything outside the
// subset becomes a no-op without register write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_idu (
  input  logic [31:0]         ins,
  output core_bus_pkg::dec_t  ctl
);

  import rv_isa_pkg::*;
  import core_bus_pkg::*;

  opc_t       opc;
  logic [2:0] fn3;
  logic [6:0] fn7;

  assign opc = opc_t'(ins[6:0]);
  assign fn3 = ins[14:12];
  assign fn7 = ins[31:25];

  always_comb begin
    logic vld;
    vld        = 1'b1;
    ctl.opc    = opc;
    ctl.alu_op = ADD;
    ctl.a_pc   = 1'b0;
    ctl.b_imm  = 1'b0;
    ctl.br_fn3 = fn3_br_t'(fn3);
    ctl.rs1    = ins[19:15];
    ctl.rs2    = ins[24:20];
    ctl.rd     = ins[11:7];
    ctl.imm    = imm_i(ins);
    ctl.wb_sel = WB_NONE;
    case (opc)
      // register-register, funct7 picks SUB
      OP: begin
        ctl.wb_sel = WB_ALU;
        case (fn3)
          3'b000 : ctl.alu_op = fn7[5] ? SUB : ADD;
          3'b010 : ctl.alu_op = SLT;
          3'b011 : ctl.alu_op = SLTU;
          3'b100 : ctl.alu_op = XOR;
          3'b110 : ctl.alu_op = OR;
          3'b111 : ctl.alu_op = AND;
          default: vld = 1'b0;
        endcase
        if (fn7 != 7'b0000000 && !(fn7 == 7'b0100000 && fn3 == 3'b000)) begin
          vld = 1'b0;
        end
      end
      OP_IMM: begin
        ctl.b_imm  = 1'b1;
        ctl.wb_sel = WB_ALU;
        case (fn3)
          3'b000 : ctl.alu_op = ADD;
          3'b010 : ctl.alu_op = SLT;
          3'b100 : ctl.alu_op = XOR;
          3'b110 : ctl.alu_op = OR;
          3'b111 : ctl.alu_op = AND;
          default: vld = 1'b0;
        endcase
      end
      LUI: begin
        ctl.alu_op = PASS_B;
        ctl.b_imm  = 1'b1;
        ctl.imm    = imm_u(ins);
        ctl.wb_sel = WB_ALU;
      end
      AUIPC: begin
        ctl.a_pc   = 1'b1;
        ctl.b_imm  = 1'b1;
        ctl.imm    = imm_u(ins);
        ctl.wb_sel = WB_ALU;
      end
      // word accesses only
      LOAD: begin
        ctl.b_imm  = 1'b1;
        ctl.wb_sel = WB_LSU;
        vld        = (fn3 == 3'b010);
      end
      STORE: begin
        ctl.b_imm = 1'b1;
        ctl.imm   = imm_s(ins);
        vld       = (fn3 == 3'b010);
      end
      // compare through subtract, signed for BLT/BGE
      BRANCH: begin
        ctl.alu_op = fn3[2] ? SLT : SUB;
        ctl.imm    = imm_b(ins);
        vld        = (fn3[1] == 1'b0);
      end
      JAL: begin
        ctl.a_pc   = 1'b1;
        ctl.b_imm  = 1'b1;
        ctl.imm    = imm_j(ins);
        ctl.wb_sel = WB_PC4;
      end
      JALR: begin
        ctl.b_imm  = 1'b1;
        ctl.wb_sel = WB_PC4;
        vld        = (fn3 == 3'b000);
      end
      default: vld = 1'b0;
    endcase
    // harmless no-op, no memory access and no write
    if (!vld) begin
      ctl.opc    = OP_IMM;
      ctl.wb_sel = WB_NONE;
    end
  end

endmodule

// File: hdl/core_lsu.sv
//////////////////////////////////////////////////////////////////////
// load/store unit
// aligned word requests on the data bus during execute, done
// pulse in the response cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_lsu (
  input  logic                         clk,
  input  logic                         rst,
  input  core_bus_pkg::dec_t           ctl,
  input  logic                         exe_vld,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs1,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs2,
  input  logic                         lsu_rdy,
  input  core_bus_pkg::bus_rsp_t       lsu_rsp,
  output logic                         lsu_vld,
  output core_bus_pkg::bus_req_t       lsu_req,
  output logic [rv_isa_pkg::XLEN-1:0]  rdt,
  output logic                         done
);

  import rv_isa_pkg::*;

  logic [XLEN-1:0] adr;

  // base plus I or S immediate, decoder picked the format
  assign adr = rs1 + ctl.imm;

  // request held until rdy, exe_vld drops after the transfer
  assign lsu_vld = exe_vld && (ctl.opc == LOAD || ctl.opc == STORE);

  assign lsu_req = '{wen: (ctl.opc == STORE), adr: adr, wdt: rs2, ben: 4'hf};

  // response cycle marker
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= lsu_vld & lsu_rdy;
    end
  end

  // memory keeps rdt until the next data transfer
  assign rdt = lsu_rsp.rdt;

  a_adr_align : assert property (@(posedge clk) disable iff (rst)
    lsu_vld |-> (lsu_req.adr[1:0] == 2'b00));

  a_req_hold : assert property (@(posedge clk) disable iff (rst)
    (lsu_vld && !lsu_rdy) |=> (lsu_vld && $stable(lsu_req)));

endmodule

// File: core/core_ctl.sv
//////////////////////////////////////////////////////////////////////
// core control
// run flag, program counter, fetch requests, stall from both
// buses, next PC select and write-back select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_ctl #(
  parameter logic [rv_isa_pkg::XLEN-1:0] RST_ADR = '0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         ifu_rdy,
  input  core_bus_pkg::bus_rsp_t       ifu_rsp,
  input  core_bus_pkg::dec_t           ctl,
  input  logic [rv_isa_pkg::XLEN-1:0]  alu_rd,
  input  logic [rv_isa_pkg::XLEN:0]    alu_sum,
  input  logic                         tkn,
  input  logic [rv_isa_pkg::XLEN-1:0]  lsu_rdt,
  input  logic                         lsu_done,
  input  logic                         lsu_vld,
  input  logic                         lsu_rdy,
  output logic                         ifu_vld,
  output core_bus_pkg::bus_req_t       ifu_req,
  output logic [31:0]                  ins,
  output logic                         exe_vld,
  output logic [rv_isa_pkg::XLEN-1:0]  pc,
  output logic                         wb_en,
  output logic [4:0]                   wb_adr,
  output logic [rv_isa_pkg::XLEN-1:0]  wb_dat
);

  import rv_isa_pkg::*;
  import core_bus_pkg::*;

  logic            run;
  logic            ins_vld;
  // data phase of the current load/store finished
  logic            mem_ack;
  logic            mem_ins;
  logic            stall;
  logic            ret_exe;
  logic [XLEN-1:0] pc_inc;
  logic [XLEN-1:0] pcn;

  //////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run     <= 1'b0;
      ins_vld <= 1'b0;
      mem_ack <= 1'b0;
    end else begin
      run     <= 1'b1;
      ins_vld <= ins_vld | (ifu_vld & ifu_rdy);
      mem_ack <= (lsu_done | mem_ack) & ~(ifu_vld & ifu_rdy);
    end
  end

  assign mem_ins = ins_vld && (ctl.opc == LOAD || ctl.opc == STORE);

  // load/store holds off the next fetch until its data phase is over
  assign ifu_vld = run & ~(mem_ins & ~(lsu_done | mem_ack));
  assign exe_vld = ins_vld & ~lsu_done & ~mem_ack;

  assign stall = (ifu_vld & ~ifu_rdy) | (lsu_vld & ~lsu_rdy);

  assign ifu_req = '{wen: 1'b0, adr: pcn, wdt: '0, ben: 4'hf};
  assign ins     = ifu_rsp.rdt;

  //////////////////////////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RST_ADR;
    end else if (ifu_vld && !stall) begin
      pc <= pcn;
    end
  end

  assign pc_inc = pc + XLEN'(4);

  // first fetch goes to pc itself
  always_comb begin
    if (!ins_vld) begin
      pcn = pc;
    end else begin
      case (ctl.opc)
        JAL, JALR: pcn = {alu_sum[XLEN-1:1], 1'b0};
        BRANCH   : pcn = tkn ? (pc + ctl.imm) : pc_inc;
        default  : pcn = pc_inc;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write back
  //////////////////////////////////////////////////////////////////////

  // non-memory ops retire with the next fetch, loads with the response
  assign ret_exe = ins_vld & ~mem_ins & ifu_vld & ~stall;
  assign wb_en   = (ret_exe & (ctl.wb_sel == WB_ALU || ctl.wb_sel == WB_PC4)) |
                   (lsu_done & (ctl.wb_sel == WB_LSU));
  assign wb_adr  = ctl.rd;

  always_comb begin
    case (ctl.wb_sel)
      WB_LSU : wb_dat = lsu_rdt;
      WB_PC4 : wb_dat = pc_inc;
      default: wb_dat = alu_rd;
    endcase
  end

  a_pc_align : assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00);

  a_req_hold : assert property (@(posedge clk) disable iff (rst)
    (ifu_vld && !ifu_rdy) |=> (ifu_vld && $stable(ifu_req)));

endmodule

// File: core/core_top.sv
//////////////////////////////////////////////////////////////////////
// RV32I core top level
// control, decoder, register file, ALU and load/store unit on an
// instruction fetch port and a load/store port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_top #(
  parameter logic [rv_isa_pkg::XLEN-1:0] RST_ADR = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  // instruction fetch
  output logic                    ifu_vld,
  output core_bus_pkg::bus_req_t  ifu_req,
  input  logic                    ifu_rdy,
  input  core_bus_pkg::bus_rsp_t  ifu_rsp,
  // load/store
  output logic                    lsu_vld,
  output core_bus_pkg::bus_req_t  lsu_req,
  input  logic                    lsu_rdy,
  input  core_bus_pkg::bus_rsp_t  lsu_rsp
);

  import rv_isa_pkg::*;
  import core_bus_pkg::*;

  dec_t            idu_ctl;
  logic [31:0]     ins;
  logic            exe_vld;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] gpr_rs1;
  logic [XLEN-1:0] gpr_rs2;
  logic [XLEN-1:0] alu_rd;
  logic [XLEN:0]   alu_sum;
  logic            alu_tkn;
  logic [XLEN-1:0] lsu_rdt;
  logic            lsu_done;
  logic            wb_en;
  logic [4:0]      wb_adr;
  logic [XLEN-1:0] wb_dat;

  core_ctl #(
    .RST_ADR  (RST_ADR)
  ) core_ctl_i (
    .clk      (clk),
    .rst      (rst),
    .ifu_rdy  (ifu_rdy),
    .ifu_rsp  (ifu_rsp),
    .ctl      (idu_ctl),
    .alu_rd   (alu_rd),
    .alu_sum  (alu_sum),
    .tkn      (alu_tkn),
    .lsu_rdt  (lsu_rdt),
    .lsu_done (lsu_done),
    .lsu_vld  (lsu_vld),
    .lsu_rdy  (lsu_rdy),
    .ifu_vld  (ifu_vld),
    .ifu_req  (ifu_req),
    .ins      (ins),
    .exe_vld  (exe_vld),
    .pc       (pc),
    .wb_en    (wb_en),
    .wb_adr   (wb_adr),
    .wb_dat   (wb_dat)
  );

  core_idu core_idu_i (
    .ins      (ins),
    .ctl      (idu_ctl)
  );

  // read addresses straight from the decoder
  core_gpr core_gpr_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_adr  (idu_ctl.rs1),
    .rs2_adr  (idu_ctl.rs2),
    .rd_en    (wb_en),
    .rd_adr   (wb_adr),
    .rd_dat   (wb_dat),
    .rs1_dat  (gpr_rs1),
    .rs2_dat  (gpr_rs2)
  );

  core_alu core_alu_i (
    .ctl      (idu_ctl),
    .pc       (pc),
    .rs1      (gpr_rs1),
    .rs2      (gpr_rs2),
    .rd       (alu_rd),
    .sum      (alu_sum),
    .tkn      (alu_tkn)
  );

  core_lsu core_lsu_i (
    .clk      (clk),
    .rst      (rst),
    .ctl      (idu_ctl),
    .exe_vld  (exe_vld),
    .rs1      (gpr_rs1),
    .rs2      (gpr_rs2),
    .lsu_rdy  (lsu_rdy),
    .lsu_rsp  (lsu_rsp),
    .lsu_vld  (lsu_vld),
    .lsu_req  (lsu_req),
    .rdt      (lsu_rdt),
    .done     (lsu_done)
  );

endmodule

// File: sim/tb_mem.sv
//////////////////////////////////////////////////////////////////////
// behavioural memory for the core testbench
// one shared word array behind an instruction port and a data
// port, random ready stalls, response one cycle after transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_mem (
  input  logic                    clk,
  input  logic                    ifu_vld,
  input  core_bus_pkg::bus_req_t  ifu_req,
  output logic                    ifu_rdy,
  output core_bus_pkg::bus_rsp_t  ifu_rsp,
  input  logic                    lsu_vld,
  input  core_bus_pkg::bus_req_t  lsu_req,
  output logic                    lsu_rdy,
  output core_bus_pkg::bus_rsp_t  lsu_rsp
);

  import rv_isa_pkg::*;
  import core_bus_pkg::*;

  // 1 KiB, program low, data from 0x300
  logic [XLEN-1:0] mem [0:255];

  initial begin
    ifu_rdy = 1'b0;
    lsu_rdy = 1'b0;
    ifu_rsp = '0;
    lsu_rsp = '0;
  end

  always @(posedge clk) begin
    // ready low in about one cycle of three
    ifu_rdy <= ($urandom % 3) != 0;
    lsu_rdy <= ($urandom % 3) != 0;
    // responses held until the next transfer
    if (ifu_vld && ifu_rdy) begin
      ifu_rsp <= '{rdt: mem[ifu_req.adr[9:2]], err: 1'b0};
    end
    if (lsu_vld && lsu_rdy) begin
      if (lsu_req.wen) begin
        mem[lsu_req.adr[9:2]] <= lsu_req.wdt;
      end
      lsu_rsp <= '{rdt: mem[lsu_req.adr[9:2]], err: 1'b0};
    end
  end

endmodule

// File: sim/core_tb.sv
//////////////////////////////////////////////////////////////////////
// RV32I core testbench
// builds a small program with expected stores and fetch order,
// runs it under random ready stalls and compares the data bus
// stores and the fetch addresses against the expected table
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_tb;

  import rv_isa_pkg::*;
  import core_bus_pkg::*;

  localparam logic [XLEN-1:0] data_base = 32'h300;

  logic     clk;
  logic     rst;
  logic     ifu_vld;
  bus_req_t ifu_req;
  logic     ifu_rdy;
  bus_rsp_t ifu_rsp;
  logic     lsu_vld;
  bus_req_t lsu_req;
  logic     lsu_rdy;
  bus_rsp_t lsu_rsp;

  // program image plus expected and observed traffic
  logic [31:0]     prog [$];
  logic [XLEN-1:0] fexp [$];
  logic [XLEN-1:0] fobs [$];
  bus_req_t        sexp [$];
  bus_req_t        sobs [$];
  bus_req_t        lsu_prev;
  logic            lsu_held;
  int              mismatches;
  int              failures;
  int              timeouts;

  // x4..x17 after the arithmetic block
  // auipc sits at 0x10
  logic [XLEN-1:0] alu_exp [4:17] = '{
    32'h1234_5000, 32'h0000_1010, 32'h0000_0002, 32'h0000_000c,
    32'h1234_5007, 32'hffff_ffff, 32'h0000_0003, 32'h0000_0001,
    32'h0000_0000, 32'h0000_0001, 32'h0000_00f7, 32'hffff_fff7,
    32'h0000_00fb, 32'h0000_0001
  };

  core_top core_top_i (
    .clk     (clk),
    .rst     (rst),
    .ifu_vld (ifu_vld),
    .ifu_req (ifu_req),
    .ifu_rdy (ifu_rdy),
    .ifu_rsp (ifu_rsp),
    .lsu_vld (lsu_vld),
    .lsu_req (lsu_req),
    .lsu_rdy (lsu_rdy),
    .lsu_rsp (lsu_rsp)
  );

  tb_mem mem_i (
    .clk     (clk),
    .ifu_vld (ifu_vld),
    .ifu_req (ifu_req),
    .ifu_rdy (ifu_rdy),
    .ifu_rsp (ifu_rsp),
    .lsu_vld (lsu_vld),
    .lsu_req (lsu_req),
    .lsu_rdy (lsu_rdy),
    .lsu_rsp (lsu_rsp)
  );

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // program builder
  //////////////////////////////////////////////////////////////////////

  // exec marks words that the fetch sequence must visit
  task automatic emit(input logic [31:0] word, input bit exec);
    if (exec) begin
      fexp.push_back(XLEN'(prog.size() * 4));
    end
    prog.push_back(word);
  endtask

  // immediate read back through the decoder functions
  task automatic check_imm(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
    if (got !== want) begin
      failures++;
      $display("immediate %h does not fit its instruction format", want);
    end
  endtask

  task automatic encode_r(input logic [2:0] fn3, input logic [6:0] fn7, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
    emit({fn7, rs2, rs1, fn3, rd, OP}, 1'b1);
  endtask

  task automatic encode_i(input opc_t opc, input logic [2:0] fn3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [XLEN-1:0] imm, input bit exec);
    logic [31:0] w;
    w = {imm[11:0], rs1, fn3, rd, opc};
    check_imm(imm_i(w), imm);
    emit(w, exec);
  endtask

  // word store only
  task automatic encode_s(input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [XLEN-1:0] imm);
    logic [31:0] w;
    w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    check_imm(imm_s(w), imm);
    emit(w, 1'b1);
  endtask

  task automatic encode_b(input fn3_br_t fn3, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [XLEN-1:0] imm);
    logic [31:0] w;
    w = {imm[12], imm[10:5], rs2, rs1, fn3, imm[4:1], imm[11], BRANCH};
    check_imm(imm_b(w), imm);
    emit(w, 1'b1);
  endtask

  task automatic encode_u(input opc_t opc, input logic [4:0] rd, input logic [XLEN-1:0] imm);
    logic [31:0] w;
    w = {imm[31:12], rd, opc};
    check_imm(imm_u(w), imm);
    emit(w, 1'b1);
  endtask

  task automatic encode_j(input logic [4:0] rd, input logic [XLEN-1:0] imm);
    logic [31:0] w;
    w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    check_imm(imm_j(w), imm);
    emit(w, 1'b1);
  endtask

  // SW to the next free data slot
  // x1 holds the data base
  task automatic store_slot(input logic [4:0] rs, input logic [XLEN-1:0] val);
    logic [XLEN-1:0] off;
    bus_req_t        req;
    off = XLEN'(sexp.size() * 4);
    encode_s(5'd1, rs, off);
    req = '{wen: 1'b1, adr: data_base + off, wdt: val, ben: 4'hf};
    sexp.push_back(req);
  endtask

  // marker in x20
  // the word after the branch overwrites it unless skipped
  task automatic branch_case(input fn3_br_t fn3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input bit taken, input logic [XLEN-1:0] id);
    encode_i(OP_IMM, 3'b000, 5'd20, 5'd0, id, 1'b1);
    encode_b(fn3, rs1, rs2, 32'd8);
    encode_i(OP_IMM, 3'b000, 5'd20, 5'd0, id + 32'h100, !taken);
    store_slot(5'd20, taken ? id : id + 32'h100);
  endtask

  task automatic build_program();
    logic [XLEN-1:0] a;
    // x1 holds the data base
    // x2 = -5 and x3 = 7
    encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, data_base, 1'b1);
    encode_i(OP_IMM, 3'b000, 5'd2, 5'd0, 32'hffff_fffb, 1'b1);
    encode_i(OP_IMM, 3'b000, 5'd3, 5'd0, 32'd7, 1'b1);
    encode_u(LUI, 5'd4, 32'h1234_5000);
    encode_u(AUIPC, 5'd5, 32'h0000_1000);
    encode_r(3'b000, 7'h00, 5'd6, 5'd2, 5'd3);
    encode_r(3'b000, 7'h20, 5'd7, 5'd3, 5'd2);
    encode_r(3'b100, 7'h00, 5'd8, 5'd4, 5'd3);
    encode_r(3'b110, 7'h00, 5'd9, 5'd2, 5'd3);
    encode_r(3'b111, 7'h00, 5'd10, 5'd2, 5'd3);
    encode_r(3'b010, 7'h00, 5'd11, 5'd2, 5'd3);
    encode_r(3'b011, 7'h00, 5'd12, 5'd2, 5'd3);
    encode_i(OP_IMM, 3'b010, 5'd13, 5'd2, 32'hffff_fffc, 1'b1);
    encode_i(OP_IMM, 3'b100, 5'd14, 5'd3, 32'h0000_00f0, 1'b1);
    encode_i(OP_IMM, 3'b110, 5'd15, 5'd3, 32'hffff_fff0, 1'b1);
    encode_i(OP_IMM, 3'b111, 5'd16, 5'd2, 32'h0000_00ff, 1'b1);
    encode_r(3'b011, 7'h00, 5'd17, 5'd3, 5'd2);
    // unknown opcode retires as a no-op
    emit(32'h0000_0000, 1'b1);
    for (int r = 4; r <= 17; r++) begin
      store_slot(5'(r), alu_exp[r]);
    end
    // read back slot 0 (x4) and slot 5 (x9)
    encode_i(LOAD, 3'b010, 5'd24, 5'd1, 32'd0, 1'b1);
    store_slot(5'd24, alu_exp[4]);
    encode_i(LOAD, 3'b010, 5'd25, 5'd1, 32'd20, 1'b1);
    store_slot(5'd25, alu_exp[9]);
    branch_case(BEQ, 5'd3, 5'd3, 1'b1, 32'h11);
    branch_case(BEQ, 5'd3, 5'd2, 1'b0, 32'h12);
    branch_case(BNE, 5'd3, 5'd2, 1'b1, 32'h13);
    branch_case(BNE, 5'd3, 5'd3, 1'b0, 32'h14);
    branch_case(BLT, 5'd2, 5'd3, 1'b1, 32'h15);
    branch_case(BLT, 5'd3, 5'd2, 1'b0, 32'h16);
    branch_case(BGE, 5'd3, 5'd2, 1'b1, 32'h17);
    branch_case(BGE, 5'd2, 5'd3, 1'b0, 32'h18);
    // jal over one word with the link at its pc + 4
    a = XLEN'(prog.size() * 4);
    encode_j(5'd21, 32'd8);
    encode_i(OP_IMM, 3'b000, 5'd21, 5'd0, 32'h7ff, 1'b0);
    store_slot(5'd21, a + 32'd4);
    // jalr target a + 13 with bit 0 cleared
    a = XLEN'(prog.size() * 4);
    encode_u(AUIPC, 5'd22, 32'd0);
    encode_i(JALR, 3'b000, 5'd23, 5'd22, 32'd13, 1'b1);
    encode_i(OP_IMM, 3'b000, 5'd23, 5'd0, 32'h7ff, 1'b0);
    store_slot(5'd23, a + 32'd8);
    // park in a self loop
    encode_j(5'd0, 32'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string sig, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
    mismatches++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, want);
  endtask

  task automatic check_store(input bus_req_t got, input bus_req_t want);
    if (got.wen !== want.wen) begin
      report_mismatch("lsu_req.wen", XLEN'(got.wen), XLEN'(want.wen));
    end
    if (got.adr !== want.adr) begin
      report_mismatch("lsu_req.adr", got.adr, want.adr);
    end
    if (got.wdt !== want.wdt) begin
      report_mismatch("lsu_req.wdt", got.wdt, want.wdt);
    end
  endtask

  task automatic check_fetch(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
    if (got !== want) begin
      report_mismatch("ifu_req.adr", got, want);
    end
  endtask

  task automatic wait_stores(input int n);
    int cyc;
    cyc = 0;
    while (sobs.size() < n && cyc < 2000) begin
      @(posedge clk);
      cyc++;
    end
    if (sobs.size() < n) begin
      timeouts++;
      $display("store %0d never reached the data bus within %0d cycles", n - 1, cyc);
    end
  endtask

  task automatic wait_fetches(input int n);
    int cyc;
    cyc = 0;
    while (fobs.size() < n && cyc < 4000) begin
      @(posedge clk);
      cyc++;
    end
    if (fobs.size() < n) begin
      timeouts++;
      $display("only %0d of %0d fetches seen within %0d cycles", fobs.size(), n, cyc);
    end
  endtask

  // bus monitor samples mid cycle when vld, rdy and req are settled
  always @(negedge clk) begin
    if (rst) begin
      lsu_held = 1'b0;
      if (ifu_vld || lsu_vld) begin
        failures++;
        $display("bus valid raised during reset at %0t", $time);
      end
    end else begin
      if (lsu_held && (!lsu_vld || lsu_req !== lsu_prev)) begin
        failures++;
        $display("data request dropped or changed while stalled at %0t", $time);
      end
      if (ifu_vld && ifu_rdy) begin
        fobs.push_back(ifu_req.adr);
      end
      if (lsu_vld && lsu_rdy && lsu_req.wen) begin
        sobs.push_back(lsu_req);
      end
      lsu_held = lsu_vld && !lsu_rdy;
      lsu_prev = lsu_req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h0457faed));
    clk      = 1'b0;
    rst      = 1'b1;
    lsu_held = 1'b0;
    build_program();
    // image loaded while the core is held in reset
    for (int i = 0; i < 256; i++) begin
      mem_i.mem[i] = (i < prog.size()) ? prog[i] : {16'hdead, 16'(i)};
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // stores in table order
    for (int i = 0; i < sexp.size(); i++) begin
      wait_stores(i + 1);
      if (timeouts != 0) begin
        break;
      end
      check_store(sobs[i], sexp[i]);
    end
    if (timeouts == 0) begin
      wait_fetches(fexp.size());
    end
    if (timeouts == 0) begin
      // first entry is the reset vector
      for (int i = 0; i < fexp.size(); i++) begin
        check_fetch(fobs[i], fexp[i]);
      end
      // a repeated store would land in this idle window
      repeat (20) @(posedge clk);
      if (sobs.size() != sexp.size()) begin
        failures++;
        $display("%0d stores seen on the data bus, %0d expected", sobs.size(), sexp.size());
      end
    end
    $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatches, failures, timeouts);
    if (mismatches == 0 && failures == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
common/rv_isa_pkg.sv
common/core_bus_pkg.sv
hdl/core_gpr.sv
hdl/core_alu.sv
hdl/core_idu.sv
hdl/core_lsu.sv
core/core_ctl.sv
core/core_top.sv
sim/tb_mem.sv
sim/core_tb.sv

// File: Makefile
# Verilator flow for the RV32I core testbench

TOP = core_tb
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f \
		--top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ)
